// ==== hdl/csr_cfg.svh ====
// widths are for an RV32 machine-mode core only, and the package masks assume XLEN of 32
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// data path width
`define XLEN 32

// csr address field of the instruction
`define CSR_ADDR_W 12

// destination register index, x0..x31
`define REG_ADDR_W 5

// commit id from the issue stage, wraps freely
`define COMMIT_ID_W 4

`endif

// ==== hdl/csr_pkg.sv ====
// machine-mode CSR types and constants, masks only cover the six implemented registers
`default_nettype none

`include "csr_cfg.svh"

package csr_pkg;

    // low two bits of funct3, 2'b00 is unused here
    typedef enum logic [1:0] {
        CSR_RW = 2'b01, // write operand
        CSR_RS = 2'b10, // set bits
        CSR_RC = 2'b11  // clear bits
    } csr_op_e;

    // implemented machine-mode csr addresses
    localparam logic [`CSR_ADDR_W-1:0] CSR_MSTATUS  = 12'h300;
    localparam logic [`CSR_ADDR_W-1:0] CSR_MIE      = 12'h304;
    localparam logic [`CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
    localparam logic [`CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [`CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [`CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;

    // interrupt enable bits inside mstatus
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    // writable bits per register
    // only MIE and MPIE in mstatus
    localparam logic [`XLEN-1:0] MSTATUS_WMASK = 32'h0000_0088;
    // msie, mtie, meie
    localparam logic [`XLEN-1:0] MIE_WMASK     = 32'h0000_0888;
    // direct mode only, mode field reads zero
    localparam logic [`XLEN-1:0] MTVEC_WMASK   = 32'hffff_fffc;
    // no compressed support but bit 0 is always zero
    localparam logic [`XLEN-1:0] MEPC_WMASK    = 32'hffff_fffe;

endpackage

`default_nettype wire

// ==== hdl/csr_port_if.sv ====
// read path is combinational, the regfile owns the writable masks and applies them on write
`default_nettype none

`include "csr_cfg.svh"

interface csr_port_if;

    logic [`CSR_ADDR_W-1:0] rd_addr;
    logic [`XLEN-1:0]       rd_data;    // zero on miss
    logic                   rd_hit;     // address implemented

    logic                   wr_en;
    logic [`CSR_ADDR_W-1:0] wr_addr;
    logic [`XLEN-1:0]       wr_data;    // raw new value, unmasked

    logic                   trap_en;    // one cycle strobe
    logic [`XLEN-1:0]       trap_pc;
    logic [`XLEN-1:0]       trap_cause;

    // exec unit side drives address, write and trap
    modport exec (
        output rd_addr, wr_en, wr_addr, wr_data, trap_en, trap_pc, trap_cause,
        input  rd_data, rd_hit
    );

    // regfile side answers reads
    modport regfile (
        input  rd_addr, wr_en, wr_addr, wr_data, trap_en, trap_pc, trap_cause,
        output rd_data, rd_hit
    );

endinterface

`default_nettype wire

// ==== hdl/csr_regfile.sv ====
// six machine-mode CSRs only, trap_en and wr_en must never be high in the same cycle
`default_nettype none

`include "csr_cfg.svh"

module csr_regfile
    import csr_pkg::*;
(
    input  logic               clk,
    input  logic               reset_i,
    csr_port_if.regfile        port,
    output logic [`XLEN-1:0]   mtvec_o     // trap vector base
);

    logic [`XLEN-1:0] mstatus_q;
    logic [`XLEN-1:0] mie_q;
    logic [`XLEN-1:0] mtvec_q;
    logic [`XLEN-1:0] mscratch_q;
    logic [`XLEN-1:0] mepc_q;
    logic [`XLEN-1:0] mcause_q;

    // keep bits outside the mask, take new bits inside it
    function automatic logic [`XLEN-1:0] masked_merge(
        input logic [`XLEN-1:0] old_v,
        input logic [`XLEN-1:0] new_v,
        input logic [`XLEN-1:0] mask
    );
        return (old_v & ~mask) | (new_v & mask);
    endfunction

    // read decode, zero latency
    always_comb begin
        port.rd_hit  = 1'b1;
        port.rd_data = '0;
        case (port.rd_addr)
            CSR_MSTATUS:  port.rd_data = mstatus_q;
            CSR_MIE:      port.rd_data = mie_q;
            CSR_MTVEC:    port.rd_data = mtvec_q;
            CSR_MSCRATCH: port.rd_data = mscratch_q;
            CSR_MEPC:     port.rd_data = mepc_q;
            CSR_MCAUSE:   port.rd_data = mcause_q;
            default: begin
                port.rd_hit  = 1'b0; // unimplemented, exec unit flags illegal
                port.rd_data = '0;
            end
        endcase
    end

    // state update, trap first then csr write
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mstatus_q  <= '0;
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (port.trap_en) begin
            mepc_q   <= port.trap_pc & MEPC_WMASK; // bit 0 forced low
            mcause_q <= port.trap_cause;
            // stack the interrupt enable
            mstatus_q[MSTATUS_MPIE_BIT] <= mstatus_q[MSTATUS_MIE_BIT];
            mstatus_q[MSTATUS_MIE_BIT]  <= 1'b0;
        end else if (port.wr_en) begin
            case (port.wr_addr)
                CSR_MSTATUS: begin
                    mstatus_q <= masked_merge(mstatus_q, port.wr_data, MSTATUS_WMASK);
                end
                CSR_MIE: begin
                    mie_q <= masked_merge(mie_q, port.wr_data, MIE_WMASK);
                end
                CSR_MTVEC: begin
                    mtvec_q <= masked_merge(mtvec_q, port.wr_data, MTVEC_WMASK);
                end
                CSR_MSCRATCH: begin
                    mscratch_q <= port.wr_data; // fully writable
                end
                CSR_MEPC: begin
                    mepc_q <= masked_merge(mepc_q, port.wr_data, MEPC_WMASK);
                end
                CSR_MCAUSE: begin
                    mcause_q <= port.wr_data; // any cause code
                end
                default: begin
                    // miss, nothing changes
                end
            endcase
        end
    end

    assign mtvec_o = mtvec_q;

    // exec unit holds off requests during a trap strobe
    a_no_wr_on_trap: assert property (@(posedge clk) disable iff (reset_i)
        !(port.wr_en && port.trap_en))
        else $error("csr write and trap in the same cycle");

endmodule

`default_nettype wire

// ==== hdl/csr_exec_unit.sv ====
// one request in flight, write and result load share the accept edge, trap_i blocks accept
`default_nettype none

`include "csr_cfg.svh"

module csr_exec_unit
    import csr_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_i,

    // request from issue
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  csr_op_e                 req_op_i,
    input  logic [`CSR_ADDR_W-1:0]  req_addr_i,
    input  logic [`XLEN-1:0]        req_operand_i,  // rs1 value
    input  logic [`REG_ADDR_W-1:0]  req_rd_i,
    input  logic [`COMMIT_ID_W-1:0] req_id_i,

    // result to writeback
    output logic                    wb_valid_o,
    input  logic                    wb_ready_i,
    output logic [`REG_ADDR_W-1:0]  wb_rd_o,
    output logic [`XLEN-1:0]        wb_data_o,      // old csr value
    output logic [`COMMIT_ID_W-1:0] wb_id_o,
    output logic                    wb_illegal_o,

    // trap strobe
    input  logic                    trap_i,
    input  logic [`XLEN-1:0]        trap_pc_i,
    input  logic [`XLEN-1:0]        trap_cause_i,

    csr_port_if.exec                port
);

    logic                    accept;
    logic [`XLEN-1:0]        new_val;

    // result register
    logic                    res_valid_q;
    logic                    res_illegal_q;
    logic [`XLEN-1:0]        res_data_q;
    logic [`REG_ADDR_W-1:0]  res_rd_q;
    logic [`COMMIT_ID_W-1:0] res_id_q;

    // free slot when empty or draining this cycle
    assign req_ready_o = (~res_valid_q | wb_ready_i) & ~trap_i;
    assign accept      = req_valid_i & req_ready_o;

    // read old value straight from the request
    assign port.rd_addr = req_addr_i;

    // new value from op
    always_comb begin
        case (req_op_i)
            CSR_RW:  new_val = req_operand_i;
            CSR_RS:  new_val = port.rd_data | req_operand_i;
            CSR_RC:  new_val = port.rd_data & ~req_operand_i;
            default: new_val = port.rd_data; // reserved op, value unchanged
        endcase
    end

    // write only to implemented csrs
    assign port.wr_en   = accept & port.rd_hit;
    assign port.wr_addr = req_addr_i;
    assign port.wr_data = new_val;

    // trap passes through for one cycle
    assign port.trap_en    = trap_i;
    assign port.trap_pc    = trap_pc_i;
    assign port.trap_cause = trap_cause_i;

    // valid and illegal flag
    always_ff @(posedge clk) begin
        if (reset_i) begin
            res_valid_q   <= 1'b0;
            res_illegal_q <= 1'b0;
        end else if (accept) begin
            res_valid_q   <= 1'b1; // refill, back to back
            res_illegal_q <= ~port.rd_hit;
        end else if (wb_ready_i) begin
            res_valid_q   <= 1'b0; // taken
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (accept) begin
            res_data_q <= port.rd_hit ? port.rd_data : '0;
            res_rd_q   <= req_rd_i;
            res_id_q   <= req_id_i;
        end
    end

    assign wb_valid_o   = res_valid_q;
    assign wb_illegal_o = res_illegal_q;
    assign wb_data_o    = res_data_q;
    assign wb_rd_o      = res_rd_q;
    assign wb_id_o      = res_id_q;

    // held result must not move until writeback takes it
    a_wb_hold: assert property (@(posedge clk) disable iff (reset_i)
        wb_valid_o && !wb_ready_i
            |=> wb_valid_o && $stable({wb_data_o, wb_rd_o, wb_id_o, wb_illegal_o}))
        else $error("writeback result changed under back-pressure");

    // trap cycle accepts nothing, so no csr write reaches the regfile
    a_trap_blocks_req: assert property (@(posedge clk) disable iff (reset_i)
        trap_i |-> !req_ready_o && !port.wr_en)
        else $error("request accepted during trap");

endmodule

`default_nettype wire

// ==== hdl/csr_top.sv ====
// one cycle from accept to wb_valid_o, trap_i is a single-cycle strobe that stalls requests
`default_nettype none

`include "csr_cfg.svh"

module csr_top
    import csr_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_i,

    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  csr_op_e                 req_op_i,
    input  logic [`CSR_ADDR_W-1:0]  req_addr_i,
    input  logic [`XLEN-1:0]        req_operand_i,
    input  logic [`REG_ADDR_W-1:0]  req_rd_i,
    input  logic [`COMMIT_ID_W-1:0] req_id_i,

    output logic                    wb_valid_o,
    input  logic                    wb_ready_i,
    output logic [`REG_ADDR_W-1:0]  wb_rd_o,
    output logic [`XLEN-1:0]        wb_data_o,
    output logic [`COMMIT_ID_W-1:0] wb_id_o,
    output logic                    wb_illegal_o,

    input  logic                    trap_i,
    input  logic [`XLEN-1:0]        trap_pc_i,
    input  logic [`XLEN-1:0]        trap_cause_i,

    output logic [`XLEN-1:0]        trap_vector_o  // current mtvec
);

    csr_port_if u_csr_if (); // exec to regfile

    csr_exec_unit u_exec (
        .clk           (clk),
        .reset_i       (reset_i),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .req_op_i      (req_op_i),
        .req_addr_i    (req_addr_i),
        .req_operand_i (req_operand_i),
        .req_rd_i      (req_rd_i),
        .req_id_i      (req_id_i),
        .wb_valid_o    (wb_valid_o),
        .wb_ready_i    (wb_ready_i),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .wb_id_o       (wb_id_o),
        .wb_illegal_o  (wb_illegal_o),
        .trap_i        (trap_i),
        .trap_pc_i     (trap_pc_i),
        .trap_cause_i  (trap_cause_i),
        .port          (u_csr_if.exec)
    );

    csr_regfile u_regfile (
        .clk     (clk),
        .reset_i (reset_i),
        .port    (u_csr_if.regfile),
        .mtvec_o (trap_vector_o)   // straight out as the trap vector
    );

endmodule

`default_nettype wire

// ==== dv/tb_csr_top.sv ====
// self-checking testbench for csr_top, runs from a fixed LCG seed and stops on a watchdog
`default_nettype none

`include "csr_cfg.svh"

module tb_csr_top
    import csr_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 40;
    localparam int N_TESTS     = 6;
    localparam int N_REQ       = 200;    // accepted requests per random test
    localparam int TIMEOUT_NS  = N_TESTS * N_REQ * CLK_PERIOD * 4;
    localparam int MODE_SWEEP  = 0;      // read every csr in turn
    localparam int MODE_RANDOM = 1;
    localparam int MODE_MTVEC  = 2;      // writes to mtvec only
    localparam int MTVEC_IDX   = 2;

    typedef struct packed {
        logic [`XLEN-1:0]        data;
        logic [`REG_ADDR_W-1:0]  rd;
        logic [`COMMIT_ID_W-1:0] id;
        logic                    illegal;
    } result_t;

    logic                    clk = 1'b0;
    logic                    reset_i;
    logic                    req_valid_i;
    logic                    req_ready_o;
    csr_op_e                 req_op_i;
    logic [`CSR_ADDR_W-1:0]  req_addr_i;
    logic [`XLEN-1:0]        req_operand_i;
    logic [`REG_ADDR_W-1:0]  req_rd_i;
    logic [`COMMIT_ID_W-1:0] req_id_i;
    logic                    wb_valid_o;
    logic                    wb_ready_i;
    logic [`REG_ADDR_W-1:0]  wb_rd_o;
    logic [`XLEN-1:0]        wb_data_o;
    logic [`COMMIT_ID_W-1:0] wb_id_o;
    logic                    wb_illegal_o;
    logic                    trap_i;
    logic [`XLEN-1:0]        trap_pc_i;
    logic [`XLEN-1:0]        trap_cause_i;
    logic [`XLEN-1:0]        trap_vector_o;

    logic [31:0]             lcg_state = 32'hbc76d812;
    logic [`XLEN-1:0]        model_csr [6];  // mstatus mie mtvec mscratch mepc mcause
    result_t                 exp_q [$];      // results in request order
    logic [`COMMIT_ID_W-1:0] next_id;
    int                      sweep_idx;
    bit                      last_acc;
    string                   cur_test;
    int                      check_count;
    int                      error_count;
    int                      test_count;
    int                      fail_count;
    int                      err_base;
    int                      chk_base;

    csr_top uut (
        .clk           (clk),
        .reset_i       (reset_i),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .req_op_i      (req_op_i),
        .req_addr_i    (req_addr_i),
        .req_operand_i (req_operand_i),
        .req_rd_i      (req_rd_i),
        .req_id_i      (req_id_i),
        .wb_valid_o    (wb_valid_o),
        .wb_ready_i    (wb_ready_i),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .wb_id_o       (wb_id_o),
        .wb_illegal_o  (wb_illegal_o),
        .trap_i        (trap_i),
        .trap_pc_i     (trap_pc_i),
        .trap_cause_i  (trap_cause_i),
        .trap_vector_o (trap_vector_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // numerical recipes constants
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // low lcg bits cycle fast, use the upper ones
    function automatic int unsigned rand_below(input int unsigned n);
        return (next_random() >> 8) % n;
    endfunction

    function automatic int csr_index(input logic [`CSR_ADDR_W-1:0] addr);
        case (addr)
            CSR_MSTATUS:  return 0;
            CSR_MIE:      return 1;
            CSR_MTVEC:    return 2;
            CSR_MSCRATCH: return 3;
            CSR_MEPC:     return 4;
            CSR_MCAUSE:   return 5;
            default:      return -1; // not implemented
        endcase
    endfunction

    function automatic logic [`CSR_ADDR_W-1:0] addr_of(input int idx);
        case (idx)
            0:       return CSR_MSTATUS;
            1:       return CSR_MIE;
            2:       return CSR_MTVEC;
            3:       return CSR_MSCRATCH;
            4:       return CSR_MEPC;
            default: return CSR_MCAUSE;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] wmask_of(input int idx);
        case (idx)
            0:       return MSTATUS_WMASK;
            1:       return MIE_WMASK;
            2:       return MTVEC_WMASK;
            4:       return MEPC_WMASK;
            default: return '1; // mscratch and mcause
        endcase
    endfunction

    // half near the implemented block, half anywhere
    function automatic logic [`CSR_ADDR_W-1:0] pick_illegal_addr();
        logic [`CSR_ADDR_W-1:0] a;
        a = CSR_MSTATUS;
        while (csr_index(a) >= 0) begin
            if (rand_below(2) == 0)
                a = 12'h300 + rand_below(12'h50);
            else
                a = next_random() >> 12;
        end
        return a;
    endfunction

    task automatic check_value(input string what, input logic [`XLEN-1:0] expected,
                               input logic [`XLEN-1:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("Error: test %s, %s expected %h actual %h", cur_test, what, expected, actual);
        end
    endtask

    // drive one new request, nba on the rising edge
    task automatic drive_request(input int mode, input int ill_pct);
        logic [`CSR_ADDR_W-1:0] addr;
        csr_op_e                op;
        logic [`XLEN-1:0]       operand;
        operand = next_random();
        case (rand_below(3))
            0:       op = CSR_RW;
            1:       op = CSR_RS;
            default: op = CSR_RC;
        endcase
        if (mode == MODE_SWEEP) begin
            addr = addr_of(sweep_idx % 6);
            sweep_idx++;
            op = CSR_RS;      // read only, set nothing
            operand = '0;
        end else if (mode == MODE_MTVEC) begin
            addr = CSR_MTVEC;
            op = CSR_RW;
        end else if (rand_below(100) < ill_pct) begin
            addr = pick_illegal_addr();
        end else begin
            addr = addr_of(rand_below(6));
        end
        req_valid_i   <= 1'b1;
        req_op_i      <= op;
        req_addr_i    <= addr;
        req_operand_i <= operand;
        req_rd_i      <= next_random() >> 20;
        req_id_i      <= next_id;
        next_id++;
    endtask

    // called at the falling edge, predicts what the next rising edge does
    task automatic observe(output bit acc);
        result_t          exp;
        int               idx;
        logic [`XLEN-1:0] old_v;
        logic [`XLEN-1:0] new_v;
        acc = 1'b0;
        check_value("trap_vector_o", model_csr[MTVEC_IDX], trap_vector_o);
        if (last_acc)
            check_value("wb_valid_o one cycle after accept", 1, wb_valid_o);
        if (wb_valid_o && wb_ready_i) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("test %s: a result left writeback with no request outstanding",
                         cur_test);
            end else begin
                exp = exp_q.pop_front();
                check_value("wb_data_o", exp.data, wb_data_o);
                check_value("wb_rd_o", exp.rd, wb_rd_o);
                check_value("wb_id_o", exp.id, wb_id_o);
                check_value("wb_illegal_o", exp.illegal, wb_illegal_o);
            end
        end
        if (wb_valid_o && !wb_ready_i)
            check_value("req_ready_o under back-pressure", 0, req_ready_o);
        if (trap_i) begin
            check_value("req_ready_o during trap", 0, req_ready_o);
            model_csr[4] = trap_pc_i & ~32'h1;
            model_csr[5] = trap_cause_i;
            model_csr[0][MSTATUS_MPIE_BIT] = model_csr[0][MSTATUS_MIE_BIT];
            model_csr[0][MSTATUS_MIE_BIT]  = 1'b0;
        end
        if (req_valid_i && req_ready_o) begin
            acc = 1'b1;
            idx = csr_index(req_addr_i);
            if (idx < 0) begin
                exp_q.push_back('{data: '0, rd: req_rd_i, id: req_id_i, illegal: 1'b1});
            end else begin
                old_v = model_csr[idx];
                case (req_op_i)
                    CSR_RW:  new_v = req_operand_i;
                    CSR_RS:  new_v = old_v | req_operand_i;
                    default: new_v = old_v & ~req_operand_i;
                endcase
                // only the writable bits move
                model_csr[idx] = (old_v & ~wmask_of(idx)) | (new_v & wmask_of(idx));
                exp_q.push_back('{data: old_v, rd: req_rd_i, id: req_id_i, illegal: 1'b0});
            end
        end
        last_acc = acc;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_base = error_count;
        chk_base = check_count;
    endtask

    task automatic end_test();
        test_count++;
        if (error_count != err_base)
            fail_count++;
        $display("test %-14s %s, %0d checks, %0d errors", cur_test,
                 (error_count == err_base) ? "ok" : "failed",
                 check_count - chk_base, error_count - err_base);
    endtask

    // entered and left just after a rising edge
    task automatic run_test(input int mode, input int n_req, input int ill_pct,
                            input int rdy_pct, input int trap_pct);
        int accepted;
        bit acc_now;
        accepted = 0;
        acc_now  = 1'b0;
        forever begin
            if (accepted < n_req && (acc_now || !req_valid_i))
                drive_request(mode, ill_pct);
            else if (acc_now)
                req_valid_i <= 1'b0;
            wb_ready_i   <= (rand_below(100) < rdy_pct);
            trap_i       <= (accepted < n_req) && (rand_below(100) < trap_pct);
            trap_pc_i    <= next_random();
            trap_cause_i <= next_random();
            @(negedge clk);
            observe(acc_now);
            if (acc_now)
                accepted++;
            @(posedge clk);
            if (accepted >= n_req && exp_q.size() == 0)
                break;
        end
        req_valid_i <= 1'b0; // idle between tests
        wb_ready_i  <= 1'b1;
        trap_i      <= 1'b0;
    endtask

    initial begin
        reset_i       = 1'b1;
        req_valid_i   = 1'b0;
        req_op_i      = CSR_RW;
        req_addr_i    = '0;
        req_operand_i = '0;
        req_rd_i      = '0;
        req_id_i      = '0;
        wb_ready_i    = 1'b1;
        trap_i        = 1'b0;
        trap_pc_i     = '0;
        trap_cause_i  = '0;
        next_id       = '0;
        sweep_idx     = 0;
        last_acc      = 1'b0;
        check_count   = 0;
        error_count   = 0;
        test_count    = 0;
        fail_count    = 0;
        for (int i = 0; i < 6; i++)
            model_csr[i] = '0;

        repeat (4) @(posedge clk);
        reset_i <= 1'b0;

        begin_test("reset_values");
        @(negedge clk);
        check_value("req_ready_o after reset", 1, req_ready_o);
        check_value("wb_valid_o after reset", 0, wb_valid_o);
        check_value("trap_vector_o after reset", 0, trap_vector_o);
        @(posedge clk);
        run_test(MODE_SWEEP, 6, 0, 100, 0);
        end_test();

        begin_test("rmw_random");
        run_test(MODE_RANDOM, N_REQ, 0, 80, 0);
        end_test();

        begin_test("illegal_addr");
        run_test(MODE_RANDOM, N_REQ, 40, 80, 0);
        end_test();

        begin_test("backpressure");
        run_test(MODE_RANDOM, N_REQ, 10, 35, 0);
        end_test();

        begin_test("trap");
        run_test(MODE_RANDOM, N_REQ, 10, 70, 15);
        end_test();

        begin_test("trap_vector");
        run_test(MODE_MTVEC, N_REQ, 0, 70, 5);
        end_test();

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, fail_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog, four cycles per request on average is plenty
    initial begin
        #(TIMEOUT_NS);
        $display("run timed out after %0d ns in test %s, results stopped arriving",
                 TIMEOUT_NS, cur_test);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_port_if.sv
hdl/csr_regfile.sv
hdl/csr_exec_unit.sv
hdl/csr_top.sv
dv/tb_csr_top.sv

// ==== Bender.yml ====
package:
  name: csr_exec

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/csr_pkg.sv
      - hdl/csr_port_if.sv
      - hdl/csr_regfile.sv
      - hdl/csr_exec_unit.sv
      - hdl/csr_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/tb_csr_top.sv
